//--- alu_core_top.f
+incdir+hw
hw/rv_alu_pkg.sv
hw/insn_decoder.sv
hw/alu_sequencer.sv
hw/int_alu.sv
hw/reg_file.sv
hw/exec_datapath.sv
hw/alu_core_top.sv
testbench/alu_core_asserts.sv
testbench/alu_core_tb.sv

//--- hw/alu_core_top.sv
`timescale 1ns/1ns
`default_nettype none

module alu_core_top (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              start,
    input  wire rv_alu_pkg::insn_t insn,
    output logic                   done,
    output logic                   wb_valid,
    output rv_alu_pkg::reg_idx_t   wb_rd,
    output rv_alu_pkg::xlen_t      wb_data,
    output rv_alu_pkg::xlen_t      pc
);
    import rv_alu_pkg::*;

    decoded_t  dec;       // held decode of the current word
    alu_ctrl_t alu_ctrl;
    dp_load_t  load;

    insn_decoder decoder_i (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .insn  (insn),
        .dec   (dec)
    );

    alu_sequencer sequencer_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .dec      (dec),
        .alu_ctrl (alu_ctrl),
        .load     (load),
        .wb_valid (wb_valid),
        .done     (done)
    );

    exec_datapath datapath_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .dec      (dec),
        .alu_ctrl (alu_ctrl),
        .load     (load),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .pc       (pc)
    );

endmodule

`default_nettype wire

//--- hw/alu_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module alu_sequencer (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 start,
    input  wire rv_alu_pkg::decoded_t dec,
    output rv_alu_pkg::alu_ctrl_t     alu_ctrl,
    output rv_alu_pkg::dp_load_t      load,
    output logic                      wb_valid,
    output logic                      done
);
    import rv_alu_pkg::*;

    seq_state_t state;
    seq_state_t next;
    logic       is_reg_class;  // both register-register forms

    assign is_reg_class = dec.cls.is_op | dec.cls.is_op_32;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next;
        end
    end

    always_comb begin
        next = state;
        case (state)
            IDLE:        next = start ? DECODE : IDLE;  // start only counts here
            DECODE:      next = is_reg_class ? EXECUTE_REG : EXECUTE_IMM;
            EXECUTE_REG: next = WRITEBACK;
            // illegal words pass one idle execute cycle and go straight to done
            EXECUTE_IMM: next = dec.cls.illegal ? DONE : WRITEBACK;
            WRITEBACK:   next = DONE;
            DONE:        next = IDLE;
            default:     next = IDLE;
        endcase
    end

    always_comb begin
        alu_ctrl = '0;
        load     = '0;
        wb_valid = 1'b0;
        done     = 1'b0;
        case (state)
            DECODE: begin
                load.load_operands = 1'b1;  // register file read ports -> operand regs
            end
            EXECUTE_REG: begin
                load.load_alu      = 1'b1;
                alu_ctrl.fn        = dec.fn;
                alu_ctrl.sub_sra   = dec.alt_bit;  // sub, sra, subw, sraw
                alu_ctrl.word_mode = dec.cls.is_op_32;
            end
            EXECUTE_IMM: begin
                load.load_alu      = !dec.cls.illegal;
                alu_ctrl.sel_b_imm = 1'b1;
                alu_ctrl.sel_a_pc  = dec.cls.is_auipc;  // pc + U immediate
                alu_ctrl.fn        = dec.cls.is_auipc ? FN_ADD : dec.fn;
                // bit 30 belongs to the immediate except on right shifts
                alu_ctrl.sub_sra   = (dec.fn == FN_SR) && dec.alt_bit && !dec.cls.is_auipc;
                alu_ctrl.word_mode = dec.cls.is_op_imm_32;
            end
            WRITEBACK: begin
                load.load_wb = 1'b1;  // rd write and pc step on the next edge
                wb_valid     = 1'b1;
            end
            DONE: begin
                done = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/exec_datapath.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_alu_config.svh"

module exec_datapath (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire rv_alu_pkg::decoded_t  dec,
    input  wire rv_alu_pkg::alu_ctrl_t alu_ctrl,
    input  wire rv_alu_pkg::dp_load_t  load,
    output rv_alu_pkg::reg_idx_t       wb_rd,
    output rv_alu_pkg::xlen_t          wb_data,
    output rv_alu_pkg::xlen_t          pc
);
    import rv_alu_pkg::*;

    xlen_t rs1_q;   // operand registers
    xlen_t rs2_q;
    xlen_t imm_q;
    xlen_t res_q;   // alu result, also the writeback data
    xlen_t pc_q;
    xlen_t rdata1;
    xlen_t rdata2;
    xlen_t op_a;
    xlen_t op_b;
    xlen_t alu_y;

    reg_file reg_file_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .rs1    (dec.rs1),
        .rs2    (dec.rs2),
        .rd     (dec.rd),
        .we     (load.load_wb),
        .wdata  (res_q),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    assign op_a = alu_ctrl.sel_a_pc ? pc_q : rs1_q;    // pc for auipc
    assign op_b = alu_ctrl.sel_b_imm ? imm_q : rs2_q;

    int_alu alu_i (
        .a    (op_a),
        .b    (op_b),
        .ctrl (alu_ctrl),
        .y    (alu_y)
    );

    always_ff @(posedge clk) begin
        if (load.load_operands) begin
            rs1_q <= rdata1;
            rs2_q <= rdata2;
            imm_q <= dec.imm;
        end
        if (load.load_alu) begin
            res_q <= alu_y;
        end
    end

    // pc only moves on a retired instruction
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= xlen_t'(`RESET_PC);
        end else if (load.load_wb) begin
            pc_q <= pc_q + xlen_t'(`PC_STEP);
        end
    end

    assign wb_rd   = dec.rd;  // decoder holds the word until done
    assign wb_data = res_q;
    assign pc      = pc_q;

endmodule

`default_nettype wire

//--- hw/insn_decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_alu_config.svh"

module insn_decoder (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              start,
    input  wire rv_alu_pkg::insn_t insn,
    output rv_alu_pkg::decoded_t   dec
);
    import rv_alu_pkg::*;

    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;

    insn_t       insn_q;    // word held for the whole sequence
    logic [2:0]  busy_cnt;  // cycles into the current sequence, zero when idle
    logic [2:0]  seq_len;   // sequence length in cycles after the start edge
    logic        accept;    // start seen while idle
    logic [6:0]  opcode;
    logic [6:0]  funct7;
    alu_fn_t     funct3;
    logic        f7_zero;   // funct7 == 0000000
    logic        f7_alt;    // funct7 == 0100000
    logic        alt_ok;    // funct3 has an alternate (sub / sra) encoding
    logic        sh_zero;   // insn[31:26] clear, 64 bit shift immediate
    logic        sh_alt;    // srai encoding in insn[31:26]
    insn_class_t cls;

    assign accept  = start && (busy_cnt == 3'd0);
    assign seq_len = cls.illegal ? 3'd3 : 3'd4;  // illegal words skip writeback

    // a start while busy must not overwrite the held word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_cnt <= 3'd0;
        end else if (accept) begin
            busy_cnt <= 3'd1;
        end else if (busy_cnt == seq_len) begin
            busy_cnt <= 3'd0;  // sequencer is back in idle
        end else if (busy_cnt != 3'd0) begin
            busy_cnt <= busy_cnt + 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            insn_q <= insn;
        end
    end

    assign opcode  = insn_q[6:0];
    assign funct3  = insn_q[14:12];
    assign funct7  = insn_q[31:25];
    assign f7_zero = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000);
    assign alt_ok  = (funct3 == FN_ADD) || (funct3 == FN_SR);
    assign sh_zero = (insn_q[31:26] == 6'b000000);
    assign sh_alt  = (insn_q[31:26] == 6'b010000);

    always_comb begin
        cls = '0;
        case (opcode)
            OPC_OP:        cls.is_op = f7_zero || (f7_alt && alt_ok);
            OPC_OP_IMM: begin
                if (funct3 == FN_SLL) begin
                    cls.is_op_imm = sh_zero;
                end else if (funct3 == FN_SR) begin
                    cls.is_op_imm = sh_zero || sh_alt;
                end else begin
                    cls.is_op_imm = 1'b1;  // no funct7 field
                end
            end
            OPC_OP_32:     cls.is_op_32 = (f7_zero && (alt_ok || funct3 == FN_SLL))
                                          || (f7_alt && alt_ok);
            OPC_OP_IMM_32: cls.is_op_imm_32 = (funct3 == FN_ADD)
                                              || (funct3 == FN_SLL && f7_zero)
                                              || (funct3 == FN_SR && (f7_zero || f7_alt));
            OPC_AUIPC:     cls.is_auipc = 1'b1;
            default:       ;
        endcase
        cls.illegal = !(cls.is_op | cls.is_op_imm | cls.is_op_32 | cls.is_op_imm_32
                        | cls.is_auipc);
    end

    assign dec.cls     = cls;
    assign dec.rd      = insn_q[11:7];
    assign dec.rs1     = insn_q[19:15];
    assign dec.rs2     = insn_q[24:20];
    assign dec.fn      = funct3;
    assign dec.alt_bit = insn_q[30];
    assign dec.imm     = cls.is_auipc ? {{(`XLEN-32){insn_q[31]}}, insn_q[31:12], 12'b0}  // U
                                      : {{(`XLEN-12){insn_q[31]}}, insn_q[31:20]};        // I

endmodule

`default_nettype wire

//--- hw/int_alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_alu_config.svh"

module int_alu (
    input  wire rv_alu_pkg::xlen_t     a,
    input  wire rv_alu_pkg::xlen_t     b,
    input  wire rv_alu_pkg::alu_ctrl_t ctrl,
    output rv_alu_pkg::xlen_t          y
);
    import rv_alu_pkg::*;

    xlen_t       res_d;    // full width result
    xlen_t       sra_d;    // arithmetic right shift, 64 bit
    logic [31:0] res_w;    // word result before sign extension
    logic [31:0] sra_w;
    logic [31:0] a_w;
    logic [31:0] b_w;
    logic [5:0]  shamt_d;  // six bit shift amount
    logic [4:0]  shamt_w;  // five bits in word mode

    assign a_w     = a[31:0];
    assign b_w     = b[31:0];
    assign shamt_d = b[5:0];
    assign shamt_w = b[4:0];
    assign sra_d   = $signed(a) >>> shamt_d;
    assign sra_w   = $signed(a_w) >>> shamt_w;

    always_comb begin
        res_d = '0;
        case (ctrl.fn)
            FN_ADD:  res_d = ctrl.sub_sra ? a - b : a + b;
            FN_SLL:  res_d = a << shamt_d;
            FN_SLT:  res_d = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            FN_SLTU: res_d = {{(`XLEN-1){1'b0}}, a < b};
            FN_XOR:  res_d = a ^ b;
            FN_SR:   res_d = ctrl.sub_sra ? sra_d : a >> shamt_d;
            FN_OR:   res_d = a | b;
            FN_AND:  res_d = a & b;
            default: res_d = '0;
        endcase
    end

    // only add, sub and the shifts have word forms
    always_comb begin
        case (ctrl.fn)
            FN_ADD:  res_w = ctrl.sub_sra ? a_w - b_w : a_w + b_w;
            FN_SLL:  res_w = a_w << shamt_w;
            FN_SR:   res_w = ctrl.sub_sra ? sra_w : a_w >> shamt_w;
            default: res_w = res_d[31:0];
        endcase
    end

    assign y = ctrl.word_mode ? {{(`XLEN-32){res_w[31]}}, res_w} : res_d;

endmodule

`default_nettype wire

//--- hw/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_alu_config.svh"

module reg_file (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire rv_alu_pkg::reg_idx_t rs1,
    input  wire rv_alu_pkg::reg_idx_t rs2,
    input  wire rv_alu_pkg::reg_idx_t rd,
    input  wire logic                 we,
    input  wire rv_alu_pkg::xlen_t    wdata,
    output rv_alu_pkg::xlen_t         rdata1,
    output rv_alu_pkg::xlen_t         rdata2
);
    import rv_alu_pkg::*;

    xlen_t regs [`NREGS];  // x0 is never written so it reads zero

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (we && (rd != '0)) begin
            regs[rd] <= wdata;  // writes to x0 dropped
        end
    end

    assign rdata1 = regs[rs1];  // combinational read ports
    assign rdata2 = regs[rs2];

endmodule

`default_nettype wire

//--- hw/rv_alu_config.svh
`ifndef RV_ALU_CONFIG_SVH
`define RV_ALU_CONFIG_SVH

// architectural sizes of the integer slice
`define XLEN 64       // integer register width
`define NREGS 32      // number of integer registers

// program counter behaviour
`define RESET_PC 0    // pc after reset
`define PC_STEP 4     // bytes per retired instruction

`endif

//--- hw/rv_alu_pkg.sv
`default_nettype none

`include "rv_alu_config.svh"

package rv_alu_pkg;

    typedef logic [`XLEN-1:0]          xlen_t;     // one integer data word
    typedef logic [31:0]               insn_t;     // raw instruction word
    typedef logic [$clog2(`NREGS)-1:0] reg_idx_t;  // register index
    typedef logic [2:0]                alu_fn_t;   // funct3 operation select

    localparam alu_fn_t FN_ADD  = 3'b000;  // add or sub
    localparam alu_fn_t FN_SLL  = 3'b001;
    localparam alu_fn_t FN_SLT  = 3'b010;
    localparam alu_fn_t FN_SLTU = 3'b011;
    localparam alu_fn_t FN_XOR  = 3'b100;
    localparam alu_fn_t FN_SR   = 3'b101;  // srl or sra
    localparam alu_fn_t FN_OR   = 3'b110;
    localparam alu_fn_t FN_AND  = 3'b111;

    typedef struct packed {
        logic is_op;         // register-register, 64 bit
        logic is_op_imm;     // register-immediate, 64 bit
        logic is_op_32;      // register-register word form
        logic is_op_imm_32;  // register-immediate word form
        logic is_auipc;
        logic illegal;       // anything this slice does not run
    } insn_class_t;

    typedef struct packed {
        insn_class_t cls;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        alu_fn_t     fn;       // funct3 field
        logic        alt_bit;  // insn bit 30, selects sub / sra
        xlen_t       imm;      // sign extended I or U immediate
    } decoded_t;

    typedef struct packed {
        logic    sel_a_pc;   // operand a from pc
        logic    sel_b_imm;  // operand b from immediate
        logic    word_mode;  // 32 bit operation, sign extended result
        logic    sub_sra;    // subtract / arithmetic right shift
        alu_fn_t fn;
    } alu_ctrl_t;

    typedef struct packed {
        logic load_operands;  // capture rs1, rs2 and immediate
        logic load_alu;       // capture alu result
        logic load_wb;        // write rd and step the pc
    } dp_load_t;

    typedef enum logic [2:0] {
        IDLE,
        DECODE,
        EXECUTE_REG,
        EXECUTE_IMM,
        WRITEBACK,
        DONE
    } seq_state_t;

endpackage

`default_nettype wire

//--- testbench/alu_core_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module alu_core_asserts (
    input wire logic                   clk,
    input wire logic                   rst_n,
    input wire rv_alu_pkg::seq_state_t state,
    input wire rv_alu_pkg::dp_load_t   load,
    input wire logic                   wb_valid,
    input wire logic                   done
);
    import rv_alu_pkg::*;

    int fail_count = 0;  // assertion failures so far

    a_done_wb_apart: assert property (
        @(posedge clk) disable iff (!rst_n) !(done && wb_valid)
    ) else begin
        fail_count++;
        $error("done and wb_valid high in the same cycle");
    end

    a_wb_then_done: assert property (
        @(posedge clk) disable iff (!rst_n) wb_valid |=> done
    ) else begin
        fail_count++;
        $error("done did not follow wb_valid");
    end

    a_done_then_idle: assert property (
        @(posedge clk) disable iff (!rst_n) done |=> state == IDLE
    ) else begin
        fail_count++;
        $error("sequencer not idle after done");
    end

    a_idle_no_load: assert property (
        @(posedge clk) disable iff (!rst_n) state == IDLE |-> load == '0
    ) else begin
        fail_count++;
        $error("load strobe active while idle");
    end

endmodule

bind alu_sequencer alu_core_asserts asserts_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .state    (state),
    .load     (load),
    .wb_valid (wb_valid),
    .done     (done)
);

`default_nettype wire

//--- testbench/alu_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_alu_config.svh"

module alu_core_tb;
    import rv_alu_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_TESTS    = 28;  // rows in the stimulus table

    localparam logic [6:0] OP        = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_32     = 7'b0111011;
    localparam logic [6:0] OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] AUIPC     = 7'b0010111;
    localparam logic [6:0] F7_ZERO   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;  // sub / sra

    logic     clk;
    logic     rst_n;
    logic     start;
    insn_t    insn;
    logic     done;
    logic     wb_valid;
    reg_idx_t wb_rd;
    xlen_t    wb_data;
    xlen_t    pc;

    insn_t    insn_tab [NUM_TESTS];
    logic     wb_tab   [NUM_TESTS];  // writeback expected for a legal word
    reg_idx_t rd_tab   [NUM_TESTS];
    xlen_t    data_tab [NUM_TESTS];
    logic     poke_tab [NUM_TESTS];  // extra start pulse while busy
    string    name_tab [NUM_TESTS];
    insn_t    poke_insn;             // word offered by the ignored start
    int       n_entries;
    int       errors;
    int       test_count;
    int       failed_tests;

    alu_core_top alu_core_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .insn     (insn),
        .done     (done),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .pc       (pc)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic insn_t r_type(input logic [6:0] f7, input int rs2, input int rs1,
                                     input alu_fn_t f3, input int rd, input logic [6:0] opc);
        return {f7, reg_idx_t'(rs2), reg_idx_t'(rs1), f3, reg_idx_t'(rd), opc};
    endfunction

    function automatic insn_t i_type(input logic [11:0] imm, input int rs1, input alu_fn_t f3,
                                     input int rd, input logic [6:0] opc);
        return {imm, reg_idx_t'(rs1), f3, reg_idx_t'(rd), opc};
    endfunction

    function automatic insn_t u_type(input logic [19:0] imm, input int rd, input logic [6:0] opc);
        return {imm, reg_idx_t'(rd), opc};
    endfunction

    task automatic add_entry(input string name, input insn_t word, input int wb, input int rd,
                             input xlen_t data);
        name_tab[n_entries] = name;
        insn_tab[n_entries] = word;
        wb_tab[n_entries]   = (wb != 0);
        rd_tab[n_entries]   = reg_idx_t'(rd);
        data_tab[n_entries] = data;
        poke_tab[n_entries] = 1'b0;
        n_entries++;
    endtask

    task automatic add_busy_entry(input string name, input insn_t word, input int rd,
                                  input xlen_t data);
        add_entry(name, word, 1, rd, data);
        poke_tab[n_entries - 1] = 1'b1;
    endtask

    // chained program from zeroed registers
    // each legal word sits at pc 4 * legal words before it
    task automatic build_table();
        poke_insn = i_type(12'h7ff, 0, FN_ADD, 24, OP_IMM);  // would give x24 = 0x7ff
        add_entry("addi", i_type(12'h005, 0, FN_ADD, 1, OP_IMM), 1, 1, 64'h5);
        add_entry("addi neg", i_type(12'hffd, 0, FN_ADD, 2, OP_IMM), 1, 2, -64'sd3);
        add_entry("add", r_type(F7_ZERO, 2, 1, FN_ADD, 3, OP), 1, 3, 64'h2);
        add_entry("sub", r_type(F7_ALT, 2, 1, FN_ADD, 4, OP), 1, 4, 64'h8);
        add_entry("xori", i_type(12'h0f0, 1, FN_XOR, 5, OP_IMM), 1, 5, 64'hf5);
        add_entry("or", r_type(F7_ZERO, 4, 5, FN_OR, 6, OP), 1, 6, 64'hfd);
        add_entry("and", r_type(F7_ZERO, 2, 6, FN_AND, 7, OP), 1, 7, 64'hfd);
        add_entry("andi", i_type(12'h00f, 6, FN_AND, 8, OP_IMM), 1, 8, 64'hd);
        add_entry("slt", r_type(F7_ZERO, 1, 2, FN_SLT, 9, OP), 1, 9, 64'h1);  // -3 < 5
        add_entry("sltu", r_type(F7_ZERO, 1, 2, FN_SLTU, 10, OP), 1, 10, 64'h0);
        add_entry("sltiu", i_type(12'hfff, 1, FN_SLTU, 11, OP_IMM), 1, 11, 64'h1);
        add_entry("slli", i_type(12'h03c, 1, FN_SLL, 12, OP_IMM), 1, 12, 64'h5000000000000000);
        add_entry("srli", i_type(12'h004, 2, FN_SR, 13, OP_IMM), 1, 13, 64'h0fffffffffffffff);
        add_entry("srai", i_type(12'h401, 2, FN_SR, 14, OP_IMM), 1, 14, -64'sd2);  // bit 30 set
        add_entry("sll", r_type(F7_ZERO, 4, 1, FN_SLL, 15, OP), 1, 15, 64'h500);
        add_entry("sra", r_type(F7_ALT, 1, 2, FN_SR, 16, OP), 1, 16, -64'sd1);
        add_entry("addw", r_type(F7_ZERO, 1, 13, FN_ADD, 17, OP_32), 1, 17, 64'h4);  // wraps
        add_entry("subw", r_type(F7_ALT, 4, 1, FN_ADD, 18, OP_32), 1, 18, -64'sd3);
        add_entry("sllw", r_type(F7_ZERO, 16, 1, FN_SLL, 19, OP_32), 1, 19,
                  64'hffffffff80000000);  // shift of 31, not 63
        add_entry("sraiw", i_type(12'h404, 19, FN_SR, 20, OP_IMM_32), 1, 20,
                  64'hfffffffff8000000);
        add_entry("auipc", u_type(20'h12345, 21, AUIPC), 1, 21, 64'h12345050);  // pc 0x50
        add_entry("illegal load", 32'h00003083, 0, 0, 64'h0);
        add_entry("auipc neg", u_type(20'hfffff, 22, AUIPC), 1, 22,
                  64'hfffffffffffff054);  // pc still 0x54
        add_entry("addi to x0", i_type(12'h007, 1, FN_ADD, 0, OP_IMM), 1, 0, 64'hc);
        add_entry("add from x0", r_type(F7_ZERO, 1, 0, FN_ADD, 23, OP), 1, 23, 64'h5);
        add_entry("illegal mul", r_type(7'b0000001, 2, 1, FN_ADD, 1, OP), 0, 0, 64'h0);
        add_busy_entry("addi busy start", i_type(12'h001, 1, FN_ADD, 24, OP_IMM), 24, 64'h6);
        add_entry("add after busy", r_type(F7_ZERO, 1, 24, FN_ADD, 25, OP), 1, 25, 64'hb);
    endtask

    task automatic check_value(input string name, input xlen_t actual, input xlen_t expected);
        if (actual !== expected) begin
            $display("mismatch %s: got %h, expected %h", name, actual, expected);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (errors == errors_before) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: failed, %0d mismatches", test_count, name,
                     errors - errors_before);
        end
    endtask

    // called on a falling edge with the DUT idle and returns on the next idle falling edge
    task automatic run_entry(input int i, input xlen_t exp_pc);
        int       latency;
        int       wb_count;
        int       errors_before;
        reg_idx_t got_rd;
        xlen_t    got_data;
        errors_before = errors;
        wb_count      = 0;
        got_rd        = '0;
        got_data      = '0;
        insn          = insn_tab[i];
        start         = 1'b1;
        @(negedge clk);                 // decode cycle
        start   = poke_tab[i];          // this start must be ignored
        latency = 1;
        if (poke_tab[i]) begin
            insn = poke_insn;
        end
        while (!done) begin
            if (wb_valid) begin
                wb_count++;
                got_rd   = wb_rd;
                got_data = wb_data;
            end
            @(negedge clk);
            start = 1'b0;
            latency++;
        end
        check_value("latency", latency, wb_tab[i] ? 4 : 3);
        check_value("wb_valid count", wb_count, wb_tab[i] ? 1 : 0);
        if (wb_tab[i]) begin
            check_value("wb_rd", xlen_t'(got_rd), xlen_t'(rd_tab[i]));
            check_value("wb_data", got_data, data_tab[i]);
        end
        check_value("pc", pc, exp_pc);  // already stepped during done
        report_test(name_tab[i], errors_before);
        @(negedge clk);                 // back in idle
    endtask

    initial begin : main_seq
        xlen_t exp_pc;
        int    errors_before;
        int    total_errors;
        clk          = 1'b0;
        rst_n        = 1'b0;
        start        = 1'b0;
        insn         = '0;
        errors       = 0;
        test_count   = 0;
        failed_tests = 0;
        n_entries    = 0;
        build_table();
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        errors_before = errors;
        check_value("done", xlen_t'(done), '0);
        check_value("wb_valid", xlen_t'(wb_valid), '0);
        check_value("pc", pc, xlen_t'(`RESET_PC));
        report_test("reset", errors_before);
        exp_pc = xlen_t'(`RESET_PC);
        for (int i = 0; i < n_entries; i++) begin
            if (wb_tab[i]) begin
                exp_pc = exp_pc + xlen_t'(`PC_STEP);  // only legal words retire
            end
            run_entry(i, exp_pc);
        end
        total_errors = errors + alu_core_i.sequencer_i.asserts_i.fail_count;
        $display("tests %0d, passed %0d, failed %0d, mismatches %0d, assertion failures %0d",
                 test_count, test_count - failed_tests, failed_tests, errors,
                 alu_core_i.sequencer_i.asserts_i.fail_count);
        if (total_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // eight cycles per row is about twice the longest sequence
    initial begin : watchdog
        #((RESET_CYCLES + NUM_TESTS * 8) * CLK_PERIOD);
        $display("timeout: the DUT stopped answering with done, run aborted");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
